/* common/lic_macros.svh */
// TCDM interconnect sizing
`ifndef LIC_MACROS_SVH
`define LIC_MACROS_SVH

// Initiators sharing the banks
`define LIC_N_INIT 4

// Word-interleaved banks, selected by address bit 2
`define LIC_N_BANK 2

// Byte address and data word widths
`define LIC_ADDR_W 16
`define LIC_DATA_W 32

// Words held in each bank
`define LIC_BANK_DEPTH 256

`endif

/* common/lic_pkg.sv */
// TCDM interconnect types
`default_nettype none

`include "lic_macros.svh"

package lic_pkg;

  // Request payload carried through the arbitration tree
  typedef struct packed {
    logic [`LIC_ADDR_W-1:0]   add;
    // Write when set
    logic                     wen;
    logic [`LIC_DATA_W-1:0]   wdata;
    // One enable per byte lane
    logic [`LIC_DATA_W/8-1:0] be;
    // One-hot initiator tag
    logic [`LIC_N_INIT-1:0]   id;
  } req_payload_t;

  // Bank response, returned by ID
  typedef struct packed {
    logic                   r_valid;
    logic [`LIC_DATA_W-1:0] r_rdata;
    logic [`LIC_N_INIT-1:0] r_id;
  } resp_t;

  // Binary initiator index
  typedef logic [$clog2(`LIC_N_INIT)-1:0] init_idx_t;

  // Round-robin state of one bank
  // Bit 1 steers the leaves, bit 0 the root
  typedef logic [1:0] rr_cnt_t;

endpackage

`default_nettype wire

/* common/lic_req_if.sv */
// Request/grant link
`default_nettype none

interface lic_req_if #(
  parameter type payload_t = lic_pkg::req_payload_t
);

  // Held high until gnt is seen
  logic     req;
  // Stable while req waits
  payload_t payload_q;
  // Combinational from req and the round-robin flags
  logic     gnt;

  // Requesting side
  modport initiator (
    output req,
    output payload_q,
    input  gnt
  );

  // Arbitration side
  modport target (
    input  req,
    input  payload_q,
    output gnt
  );

endinterface

`default_nettype wire

/* arb_tree/fan_in_req.sv */
// Round-robin fan-in node
`default_nettype none

module fan_in_req #(
  parameter type payload_t = lic_pkg::req_payload_t
) (
  // High gives side 1 priority on contention
  input  logic     rr_flag_i,

  // Leaf side
  input  logic     req0_i,
  input  logic     req1_i,
  input  payload_t pay0_i,
  input  payload_t pay1_i,
  output logic     gnt0_o,
  output logic     gnt1_o,

  // Root side
  output logic     req_o,
  output payload_t pay_o,
  input  logic     gnt_i
);

  logic sel;

  // Either leaf makes a request upward
  assign req_o = req0_i | req1_i;

  // Side 1 when side 0 idle
  // or both contend and the flag favours side 1
  assign sel = ~req0_i | (rr_flag_i & req1_i);

  // Grant only to the selected side
  assign gnt0_o = req0_i & ~sel & gnt_i;
  assign gnt1_o = req1_i &  sel & gnt_i;

  // Payload mux
  always_comb begin
    if (sel) begin
      pay_o = pay1_i;
    end else begin
      pay_o = pay0_i;
    end
  end

endmodule

`default_nettype wire

/* arb_tree/arb_tree_req.sv */
// Per-bank request arbitration tree
`default_nettype none

`include "lic_macros.svh"

module arb_tree_req #(
  // Value of the bank bit served here
  parameter int unsigned BANK_IDX = 0
) (
  lic_req_if.target        init_tgt [`LIC_N_INIT],

  // Round-robin flags for both levels
  input  lic_pkg::rr_cnt_t rr_cnt_i,

  // Root request towards the bank
  output logic             req_o,
  output lic_pkg::req_payload_t pay_o,
  input  logic             gnt_i
);

  import lic_pkg::*;

  // Bank select sits just above the byte offset
  localparam int unsigned BANK_BIT = $clog2(`LIC_DATA_W/8);

  // Requests filtered by bank
  logic [`LIC_N_INIT-1:0] req_m;
  logic [`LIC_N_INIT-1:0] gnt_l;
  req_payload_t           pay_in [`LIC_N_INIT];

  // Leaf outputs, one per pair
  logic [1:0]             lvl_req;
  logic [1:0]             lvl_gnt;
  req_payload_t           lvl_pay [2];

  ////////////////////////////////////////////////////////////
  // Bank filter
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `LIC_N_INIT; i++) begin : g_filter
    // Other bank's traffic never enters this tree
    assign req_m[i]  = init_tgt[i].req &
                       (init_tgt[i].payload_q.add[BANK_BIT] == BANK_IDX[0]);
    assign pay_in[i] = init_tgt[i].payload_q;
    assign init_tgt[i].gnt = gnt_l[i];
  end

  ////////////////////////////////////////////////////////////
  // Leaf level, pairs 0/1 and 2/3
  ////////////////////////////////////////////////////////////

  for (genvar p = 0; p < 2; p++) begin : g_leaf
    fan_in_req #(
      .payload_t (req_payload_t)
    ) i_fan_in (
      .rr_flag_i (rr_cnt_i[1]),
      .req0_i    (req_m[2*p]),
      .req1_i    (req_m[2*p+1]),
      .pay0_i    (pay_in[2*p]),
      .pay1_i    (pay_in[2*p+1]),
      .gnt0_o    (gnt_l[2*p]),
      .gnt1_o    (gnt_l[2*p+1]),
      .req_o     (lvl_req[p]),
      .pay_o     (lvl_pay[p]),
      .gnt_i     (lvl_gnt[p])
    );
  end

  // Root node alternates between the pairs
  fan_in_req #(
    .payload_t (req_payload_t)
  ) i_fan_in_root (
    .rr_flag_i (rr_cnt_i[0]),
    .req0_i    (lvl_req[0]),
    .req1_i    (lvl_req[1]),
    .pay0_i    (lvl_pay[0]),
    .pay1_i    (lvl_pay[1]),
    .gnt0_o    (lvl_gnt[0]),
    .gnt1_o    (lvl_gnt[1]),
    .req_o     (req_o),
    .pay_o     (pay_o),
    .gnt_i     (gnt_i)
  );

endmodule

`default_nettype wire

/* logic/rr_flag_gen.sv */
// Round-robin flag counter
`default_nettype none

module rr_flag_gen (
  input  logic             clk_i,
  input  logic             rst_n_i,

  // Root handshake of the bank
  input  logic             req_i,
  input  logic             gnt_i,

  // Flags for the tree levels
  output lic_pkg::rr_cnt_t rr_cnt_o
);

  import lic_pkg::*;

  rr_cnt_t cnt_q;
  logic    hs;

  // Transfer at the root this cycle
  assign hs = req_i & gnt_i;

  // Advance only on a transfer
  // so a stalled or idle bank keeps its turn order
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (hs) begin
      // Wraps after four grants
      cnt_q <= cnt_q + rr_cnt_t'(1);
    end
  end

  // Leaf flag is bit 1, root flag bit 0
  // giving the order 0, 2, 1, 3
  assign rr_cnt_o = cnt_q;

endmodule

`default_nettype wire

/* logic/bank_mem.sv */
// Single-port memory bank
`default_nettype none

`include "lic_macros.svh"

module bank_mem (
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  // Root request from the tree
  input  logic                  req_i,
  input  lic_pkg::req_payload_t pay_i,

  // Back-pressure
  input  logic                  stall_i,
  output logic                  gnt_o,

  // Response towards the initiator router
  output lic_pkg::resp_t        resp_o
);

  import lic_pkg::*;

  localparam int unsigned N_BYTE   = `LIC_DATA_W / 8;
  localparam int unsigned IDX_W    = $clog2(`LIC_BANK_DEPTH);
  // Word index starts above the bank bit
  localparam int unsigned WORD_LSB = $clog2(N_BYTE) + 1;

  logic [`LIC_DATA_W-1:0] mem [`LIC_BANK_DEPTH];
  logic [IDX_W-1:0]       word_idx;
  logic                   hs;
  logic                   wr_en;

  // Always ready unless stalled
  assign gnt_o = ~stall_i;

  assign hs       = req_i & gnt_o;
  assign word_idx = pay_i.add[WORD_LSB +: IDX_W];

  // No writes while held in reset
  assign wr_en = hs & pay_i.wen & rst_n_i;

  ////////////////////////////////////////////////////////////
  // Byte-masked write at the handshake edge
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    for (int b = 0; b < N_BYTE; b++) begin
      if (wr_en && pay_i.be[b]) begin
        mem[word_idx][8*b +: 8] <= pay_i.wdata[8*b +: 8];
      end
    end
  end

  // Response read straight from the array
  // The router's output stage supplies the cycle of latency
  assign resp_o.r_valid = hs;
  // Writes answer with zero data
  assign resp_o.r_rdata = pay_i.wen ? '0 : mem[word_idx];
  assign resp_o.r_id    = pay_i.id;

endmodule

`default_nettype wire

/* logic/init_side_route.sv */
// Initiator-side grant merge and response router
`default_nettype none

`include "lic_macros.svh"

module init_side_route (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,

  // Grants from each bank tree
  input  logic [`LIC_N_BANK-1:0][`LIC_N_INIT-1:0]     bank_gnt_i,
  input  lic_pkg::resp_t [`LIC_N_BANK-1:0]            resp_i,

  // Per-initiator outputs
  output logic [`LIC_N_INIT-1:0]                      gnt_o,
  output logic [`LIC_N_INIT-1:0]                      r_valid_o,
  output logic [`LIC_N_INIT-1:0][`LIC_DATA_W-1:0]     r_rdata_o
);

  import lic_pkg::*;

  init_idx_t                                resp_idx [`LIC_N_BANK];
  logic [`LIC_N_INIT-1:0]                   valid_d;
  logic [`LIC_N_INIT-1:0][`LIC_DATA_W-1:0]  rdata_d;

  // One-hot tag to index
  function automatic init_idx_t onehot_to_idx(input logic [`LIC_N_INIT-1:0] oh);
    init_idx_t idx;
    idx = '0;
    for (int i = 0; i < `LIC_N_INIT; i++) begin
      if (oh[i]) begin
        idx = init_idx_t'(i);
      end
    end
    return idx;
  endfunction

  // At most one bank grants an initiator per cycle
  always_comb begin
    gnt_o = '0;
    for (int b = 0; b < `LIC_N_BANK; b++) begin
      gnt_o = gnt_o | bank_gnt_i[b];
    end
  end

  for (genvar b = 0; b < `LIC_N_BANK; b++) begin : g_idx
    assign resp_idx[b] = onehot_to_idx(resp_i[b].r_id);
  end

  ////////////////////////////////////////////////////////////
  // Response demux
  ////////////////////////////////////////////////////////////

  // Two banks may answer different initiators together
  always_comb begin
    valid_d = '0;
    rdata_d = '0;
    for (int b = 0; b < `LIC_N_BANK; b++) begin
      if (resp_i[b].r_valid) begin
        valid_d[resp_idx[b]] = 1'b1;
        rdata_d[resp_idx[b]] = resp_i[b].r_rdata;
      end
    end
  end

  // Registered outputs, one cycle after the handshake
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      r_valid_o <= '0;
    end else begin
      r_valid_o <= valid_d;
    end
  end

  // Data captured only for a live response
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < `LIC_N_INIT; i++) begin
      if (valid_d[i]) begin
        r_rdata_o[i] <= rdata_d[i];
      end
    end
  end

endmodule

`default_nettype wire

/* logic/tcdm_lic.sv */
// TCDM logarithmic interconnect top
`default_nettype none

`include "lic_macros.svh"

module tcdm_lic (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,

  // Initiator requests
  input  logic [`LIC_N_INIT-1:0]                   req_i,
  input  logic [`LIC_N_INIT-1:0][`LIC_ADDR_W-1:0]  add_i,
  input  logic [`LIC_N_INIT-1:0]                   wen_i,
  input  logic [`LIC_N_INIT-1:0][`LIC_DATA_W-1:0]  wdata_i,
  input  logic [`LIC_N_INIT-1:0][`LIC_DATA_W/8-1:0] be_i,

  // Per-bank back-pressure
  input  logic [`LIC_N_BANK-1:0]                   bank_stall_i,

  // Grants and responses
  output logic [`LIC_N_INIT-1:0]                   gnt_o,
  output logic [`LIC_N_INIT-1:0]                   r_valid_o,
  output logic [`LIC_N_INIT-1:0][`LIC_DATA_W-1:0]  r_rdata_o
);

  import lic_pkg::*;

  req_payload_t                           init_pay [`LIC_N_INIT];
  logic [`LIC_N_BANK-1:0][`LIC_N_INIT-1:0] bank_gnt;
  resp_t [`LIC_N_BANK-1:0]                bank_resp;

  ////////////////////////////////////////////////////////////
  // Payload assembly
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `LIC_N_INIT; i++) begin : g_init
    assign init_pay[i].add   = add_i[i];
    assign init_pay[i].wen   = wen_i[i];
    assign init_pay[i].wdata = wdata_i[i];
    assign init_pay[i].be    = be_i[i];
    // Tag is the initiator's position
    assign init_pay[i].id    = `LIC_N_INIT'(1) << i;
  end

  ////////////////////////////////////////////////////////////
  // One tree, counter and memory per bank
  ////////////////////////////////////////////////////////////

  for (genvar b = 0; b < `LIC_N_BANK; b++) begin : g_bank
    lic_req_if     req_if [`LIC_N_INIT] ();
    rr_cnt_t       rr_cnt;
    logic          root_req;
    logic          root_gnt;
    req_payload_t  root_pay;

    // Every initiator reaches both trees
    for (genvar i = 0; i < `LIC_N_INIT; i++) begin : g_link
      assign req_if[i].req       = req_i[i];
      assign req_if[i].payload_q = init_pay[i];
      assign bank_gnt[b][i]      = req_if[i].gnt;
    end

    arb_tree_req #(
      .BANK_IDX (b)
    ) i_arb_tree (
      .init_tgt (req_if),
      .rr_cnt_i (rr_cnt),
      .req_o    (root_req),
      .pay_o    (root_pay),
      .gnt_i    (root_gnt)
    );

    rr_flag_gen i_rr_flag_gen (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .req_i    (root_req),
      .gnt_i    (root_gnt),
      .rr_cnt_o (rr_cnt)
    );

    bank_mem i_bank_mem (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .req_i    (root_req),
      .pay_i    (root_pay),
      .stall_i  (bank_stall_i[b]),
      .gnt_o    (root_gnt),
      .resp_o   (bank_resp[b])
    );
  end

  // Grant merge and response return
  init_side_route i_init_side_route (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .bank_gnt_i (bank_gnt),
    .resp_i     (bank_resp),
    .gnt_o      (gnt_o),
    .r_valid_o  (r_valid_o),
    .r_rdata_o  (r_rdata_o)
  );

endmodule

`default_nettype wire

/* tb/tcdm_lic_checker.sv */
// Interconnect protocol assertions
`default_nettype none

`include "lic_macros.svh"

module tcdm_lic_checker (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  input  logic [`LIC_N_INIT-1:0]                  req_i,
  input  logic [`LIC_N_INIT-1:0][`LIC_ADDR_W-1:0] add_i,
  input  logic [`LIC_N_BANK-1:0]                  bank_stall_i,
  input  logic [`LIC_N_INIT-1:0]                  gnt_o,
  input  logic [`LIC_N_INIT-1:0]                  r_valid_o
);

  timeunit 1ns;
  timeprecision 100ps;

  // Bank select sits above the byte offset
  localparam int unsigned BANK_BIT = $clog2(`LIC_DATA_W / 8);

  for (genvar i = 0; i < `LIC_N_INIT; i++) begin : g_init
    // Grant only answers a live request
    a_gnt_needs_req : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      gnt_o[i] |-> req_i[i])
      else $error("gnt without req on initiator %0d", i);

    // A stalled bank grants nobody
    a_no_stalled_gnt : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(gnt_o[i] && bank_stall_i[add_i[i][BANK_BIT]]))
      else $error("gnt from a stalled bank on initiator %0d", i);

    // Response exactly one cycle after the handshake, never otherwise
    a_resp_latency : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      r_valid_o[i] == $past(req_i[i] && gnt_o[i]))
      else $error("r_valid out of step on initiator %0d", i);
  end

endmodule

bind tcdm_lic tcdm_lic_checker i_tcdm_lic_checker (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .req_i        (req_i),
  .add_i        (add_i),
  .bank_stall_i (bank_stall_i),
  .gnt_o        (gnt_o),
  .r_valid_o    (r_valid_o)
);

`default_nettype wire

/* tb/tcdm_lic_tb.sv */
// TCDM interconnect testbench
`default_nettype none

`include "lic_macros.svh"

module tcdm_lic_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_ROWS      = 12;
  localparam int ROW_TIMEOUT = 40;

  logic                                    clk;
  logic                                    rst_n;
  logic [`LIC_N_INIT-1:0]                  req;
  logic [`LIC_N_INIT-1:0][`LIC_ADDR_W-1:0] add;
  logic [`LIC_N_INIT-1:0]                  wen;
  logic [`LIC_N_INIT-1:0][`LIC_DATA_W-1:0] wdata;
  logic [`LIC_N_INIT-1:0][3:0]             be;
  logic [`LIC_N_BANK-1:0]                  bank_stall;
  logic [`LIC_N_INIT-1:0]                  gnt;
  logic [`LIC_N_INIT-1:0]                  r_valid;
  logic [`LIC_N_INIT-1:0][`LIC_DATA_W-1:0] r_rdata;

  // Stimulus table, packed fields list initiator 3 first
  string                    row_name      [N_ROWS];
  logic [3:0]               row_mask      [N_ROWS];
  logic [3:0]               row_wen       [N_ROWS];
  logic [3:0][15:0]         row_add       [N_ROWS];
  logic [3:0][3:0]          row_be        [N_ROWS];
  logic [1:0]               row_stall     [N_ROWS];
  int                       row_stall_cyc [N_ROWS];
  // Grants expected in the first cycle of the row
  logic [3:0]               row_first     [N_ROWS];

  // Reference word array, indexed by address bits 10:2
  logic [`LIC_DATA_W-1:0]   ref_mem [`LIC_BANK_DEPTH * `LIC_N_BANK];
  // Model of each bank's round-robin counter
  logic [1:0]               cnt_m [`LIC_N_BANK];

  tcdm_lic i_tcdm_lic (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .req_i        (req),
    .add_i        (add),
    .wen_i        (wen),
    .wdata_i      (wdata),
    .be_i         (be),
    .bank_stall_i (bank_stall),
    .gnt_o        (gnt),
    .r_valid_o    (r_valid),
    .r_rdata_o    (r_rdata)
  );

  always #5 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (exp !== act) begin
      $display("ERR %s: expected 0x%0h, actual 0x%0h", name, exp, act);
      $display("tests failed");
      $fatal(1, "mismatch");
    end
  endtask

  task automatic set_row(input int r, input string name, input logic [3:0] mask,
                         input logic [3:0] w, input logic [63:0] a,
                         input logic [15:0] b, input logic [1:0] st, input int st_cyc,
                         input logic [3:0] first);
    row_name[r]      = name;
    row_mask[r]      = mask;
    row_wen[r]       = w;
    row_add[r]       = a;
    row_be[r]        = b;
    row_stall[r]     = st;
    row_stall_cyc[r] = st_cyc;
    row_first[r]     = first;
  endtask

  task automatic load_table();
    set_row(0, "reset_idle", 4'h0, 4'h0, 64'h0, 16'h0, 2'b00, 0, 4'h0);
    // Single initiator, full then partial writes, bank 0 then bank 1
    set_row(1, "wr_b0", 4'h1, 4'h1, 64'h0008, 16'h000F, 2'b00, 0, 4'h1);
    set_row(2, "wr_part_b0", 4'h1, 4'h1, 64'h0008, 16'h0005, 2'b00, 0, 4'h1);
    set_row(3, "rd_b0", 4'h1, 4'h0, 64'h0008, 16'h0000, 2'b00, 0, 4'h1);
    set_row(4, "wr_b1", 4'h2, 4'h2, {48'h000C, 16'h0}, 16'h00F0, 2'b00, 0, 4'h2);
    set_row(5, "wr_part_b1", 4'h2, 4'h2, {48'h000C, 16'h0}, 16'h00A0, 2'b00, 0, 4'h2);
    set_row(6, "rd_b1", 4'h2, 4'h0, {48'h000C, 16'h0}, 16'h0000, 2'b00, 0, 4'h2);
    // Different banks in the same cycle
    set_row(7, "par_wr", 4'hC, 4'hC, {16'h0014, 16'h0010, 32'h0}, 16'hFF00,
            2'b00, 0, 4'hC);
    // All four on bank 0 with the counter at zero
    set_row(8, "contend_wr", 4'hF, 4'hF, {16'h0038, 16'h0030, 16'h0028, 16'h0020},
            16'hFFFF, 2'b00, 0, 4'h1);
    set_row(9, "contend_rd", 4'hF, 4'h0, {16'h0038, 16'h0030, 16'h0028, 16'h0020},
            16'h0000, 2'b00, 0, 4'h1);
    set_row(10, "par_rd", 4'hD, 4'h0, {16'h0014, 16'h0010, 16'h0, 16'h000C},
            16'h0000, 2'b00, 0, 4'h5);
    // Bank 0 held off for four cycles, bank 1 keeps going
    set_row(11, "stall_b0", 4'hB, 4'h0, {16'h0014, 16'h0, 16'h0028, 16'h0020},
            16'h0000, 2'b01, 4, 4'h8);
  endtask

  // Two-input node: side 1 wins when side 0 idles or both ask and the flag is set
  function automatic logic [3:0] pick_winner(input logic [3:0] r, input logic [1:0] cnt);
    logic [1:0] leaf_req;
    logic [1:0] leaf_sel;
    logic       root_sel;
    logic [3:0] win;
    for (int p = 0; p < 2; p++) begin
      leaf_req[p] = r[2*p] | r[2*p+1];
      leaf_sel[p] = !r[2*p] || (cnt[1] && r[2*p+1]);
    end
    root_sel = !leaf_req[0] || (cnt[0] && leaf_req[1]);
    win = '0;
    if (root_sel && leaf_req[1]) begin
      win[leaf_sel[1] ? 3 : 2] = 1'b1;
    end else if (!root_sel && leaf_req[0]) begin
      win[leaf_sel[0] ? 1 : 0] = 1'b1;
    end
    return win;
  endfunction

  function automatic logic [3:0] expect_gnt(input logic [3:0] pend,
                                            input logic [3:0][15:0] adr,
                                            input logic [1:0] stall);
    logic [3:0] g;
    logic [3:0] in_bank;
    g = '0;
    for (int b = 0; b < `LIC_N_BANK; b++) begin
      for (int i = 0; i < `LIC_N_INIT; i++) begin
        in_bank[i] = pend[i] && (adr[i][2] == b[0]);
      end
      if (!stall[b]) begin
        g = g | pick_winner(in_bank, cnt_m[b]);
      end
    end
    return g;
  endfunction

  task automatic drive_inputs(input int r, input logic [3:0] pend,
                              input logic [3:0][31:0] wd, input logic [1:0] stall);
    req        = pend;
    add        = row_add[r];
    wen        = row_wen[r];
    wdata      = wd;
    be         = row_be[r];
    bank_stall = stall;
  endtask

  ////////////////////////////////////////////////////////////
  // One table row, cycle by cycle against the models
  ////////////////////////////////////////////////////////////

  task automatic run_row(input int r);
    logic [3:0]       pending;
    logic [3:0]       exp_gnt;
    logic [3:0]       exp_rv;
    logic [3:0][31:0] exp_data;
    logic [3:0][31:0] wd;
    logic [1:0]       stall_now;
    logic [8:0]       idx;
    logic             done;
    int               cyc;
    pending  = row_mask[r];
    exp_rv   = '0;
    exp_data = '0;
    cyc      = 0;
    done     = 1'b0;
    for (int i = 0; i < `LIC_N_INIT; i++) begin
      wd[i] = $urandom();
    end
    stall_now = (row_stall_cyc[r] > 0) ? row_stall[r] : 2'b00;
    @(posedge clk);
    #1;
    drive_inputs(r, pending, wd, stall_now);
    while (!done) begin
      // Mid-cycle, all inputs and outputs settled
      @(negedge clk);
      exp_gnt = expect_gnt(pending, row_add[r], stall_now);
      check_value({row_name[r], " gnt"}, exp_gnt, gnt);
      if (cyc == 0) begin
        check_value({row_name[r], " first gnt"}, row_first[r], gnt);
      end
      check_value({row_name[r], " r_valid"}, exp_rv, r_valid);
      for (int i = 0; i < `LIC_N_INIT; i++) begin
        if (exp_rv[i]) begin
          check_value($sformatf("%s r_rdata[%0d]", row_name[r], i), exp_data[i], r_rdata[i]);
        end
      end
      // Handshakes of this cycle
      for (int i = 0; i < `LIC_N_INIT; i++) begin
        if (exp_gnt[i]) begin
          idx = row_add[r][i][10:2];
          if (row_wen[r][i]) begin
            exp_data[i] = '0;
            for (int b = 0; b < 4; b++) begin
              if (row_be[r][i][b]) begin
                ref_mem[idx][8*b +: 8] = wd[i][8*b +: 8];
              end
            end
          end else begin
            exp_data[i] = ref_mem[idx];
          end
          cnt_m[row_add[r][i][2]] = cnt_m[row_add[r][i][2]] + 2'd1;
        end
      end
      exp_rv  = exp_gnt;
      pending = pending & ~exp_gnt;
      if (pending == '0 && exp_rv == '0 && cyc >= 2) begin
        done = 1'b1;
      end else if (cyc >= ROW_TIMEOUT) begin
        $display("Timeout in %s: requests or responses still open after %0d cycles",
                 row_name[r], cyc);
        $display("tests failed");
        $fatal(1, "row timed out");
      end else begin
        @(posedge clk);
        #1;
        cyc++;
        stall_now = (cyc < row_stall_cyc[r]) ? row_stall[r] : 2'b00;
        drive_inputs(r, pending, wd, stall_now);
      end
    end
  endtask

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    req        = '0;
    add        = '0;
    wen        = '0;
    wdata      = '0;
    be         = '0;
    bank_stall = '0;
    cnt_m[0]   = 2'd0;
    cnt_m[1]   = 2'd0;
    void'($urandom(32'h8887));
    load_table();
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int r = 0; r < N_ROWS; r++) begin
      run_row(r);
    end
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

/* tcdm_lic.f */
+incdir+common
common/lic_pkg.sv
common/lic_req_if.sv
arb_tree/fan_in_req.sv
arb_tree/arb_tree_req.sv
logic/rr_flag_gen.sv
logic/bank_mem.sv
logic/init_side_route.sv
logic/tcdm_lic.sv
tb/tcdm_lic_checker.sv
tb/tcdm_lic_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the TCDM interconnect testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tcdm_lic_tb
OBJ=obj_dir

verilator --binary --timing --assert -j 0 \
  --top-module "$TOP" --Mdir "$OBJ" -o "V$TOP" -f tcdm_lic.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$("./$OBJ/V$TOP" 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "all tests passed"; then
  exit 0
fi
echo "Pass line not found in simulation output"
exit 1
